// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_soc_top
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/apb_uart_bridge.sv ====
//////////////////////////////
// APB bridge to the UART
// One bus request becomes one setup and access transfer
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module apb_uart_bridge (
  input  logic               clk_i,
  input  logic               rst_i,
  soc_bus_if.target          bus_i,
  output logic               slverr_o,
  output logic               psel_o,
  output logic               penable_o,
  output logic               pwrite_o,
  output soc_pkg::addr_t     paddr_o,
  output soc_pkg::apb_data_t pwdata_o,
  input  soc_pkg::apb_data_t prdata_i,
  input  logic               pready_i,
  input  logic               pslverr_i
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    RESP
  } state_e;

  state_e             state_q;
  soc_pkg::addr_t     paddr_q;
  soc_pkg::apb_data_t pwdata_q;
  logic               pwrite_q;
  soc_pkg::apb_data_t prdata_q;
  logic               slverr_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (bus_i.req) state_q <= SETUP;
        SETUP:   state_q <= ACCESS;
        // Slow pready stretches the access phase
        ACCESS:  if (pready_i) state_q <= RESP;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request capture and APB read data
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && bus_i.req) begin
      paddr_q  <= bus_i.addr - soc_pkg::UART_BASE;
      pwdata_q <= bus_i.wdata[soc_pkg::APB_DATA_WIDTH-1:0];
      pwrite_q <= bus_i.we;
    end
    if (state_q == ACCESS && pready_i) begin
      prdata_q <= prdata_i;
      slverr_q <= pslverr_i;
    end
  end

  assign psel_o    = (state_q == SETUP) || (state_q == ACCESS);
  assign penable_o = (state_q == ACCESS);
  assign pwrite_o  = pwrite_q;
  assign paddr_o   = paddr_q;
  assign pwdata_o  = pwdata_q;

  assign bus_i.rvalid = (state_q == RESP);
  assign bus_i.rdata  = soc_pkg::data_t'(prdata_q);
  assign slverr_o     = (state_q == RESP) && slverr_q;

  // Requests arrive only between transfers
  a_req_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_i.req |-> state_q == IDLE);

endmodule

`default_nettype wire

// ==== source/ctrl_regs.sv ====
//////////////////////////////
// Control registers
// Exit code and hardware counter enable
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  logic           clk_i,
  input  logic           rst_i,
  soc_bus_if.target      bus_i,
  output soc_pkg::data_t exit_o,
  output soc_pkg::data_t hw_cnt_en_o
);

  soc_pkg::addr_t offset;
  logic           is_exit;
  logic           is_cnt_en;
  soc_pkg::data_t exit_q;
  soc_pkg::data_t cnt_en_q;
  soc_pkg::data_t rdata_q;
  logic           rvalid_q;

  assign offset    = bus_i.addr - soc_pkg::CTRL_BASE;
  assign is_exit   = (offset == soc_pkg::CTRL_EXIT_OFFSET);
  assign is_cnt_en = (offset == soc_pkg::CTRL_CNT_EN_OFFSET);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
      if (bus_i.req && bus_i.we) begin
        for (int b = 0; b < soc_pkg::STRB_WIDTH; b++) begin
          if (bus_i.be[b] && is_exit) begin
            exit_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
          end
          if (bus_i.be[b] && is_cnt_en) begin
            cnt_en_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Unused offsets read as zero
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      if (is_exit) begin
        rdata_q <= exit_q;
      end else if (is_cnt_en) begin
        rdata_q <= cnt_en_q;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign exit_o       = exit_q;
  assign hw_cnt_en_o  = cnt_en_q;

endmodule

`default_nettype wire

// ==== source/l2_mem.sv ====
//////////////////////////////
// L2 memory
// Byte-enabled, one-cycle read latency
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module l2_mem (
  input  logic       clk_i,
  soc_bus_if.target  bus_i
);

  soc_pkg::data_t                      mem [0:soc_pkg::L2_NUM_WORDS-1];
  logic [soc_pkg::L2_IDX_WIDTH-1:0]    idx;
  soc_pkg::data_t                      rdata_q;
  logic                                rvalid_q;

  // Word index above the byte offset
  assign idx = bus_i.addr[soc_pkg::BYTE_OFFSET +: soc_pkg::L2_IDX_WIDTH];

  always_ff @(posedge clk_i) begin
    if (bus_i.req && bus_i.we) begin
      for (int b = 0; b < soc_pkg::STRB_WIDTH; b++) begin
        if (bus_i.be[b]) begin
          mem[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rvalid_q <= bus_i.req;
    if (bus_i.req && !bus_i.we) begin
      rdata_q <= mem[idx];
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== source/soc_addr_decode.sv ====
//////////////////////////////
// Address decoder
// Routes one request to L2, UART or control and muxes the reply
// Unmapped addresses answer with an error
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module soc_addr_decode (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t be_i,
  output logic           resp_valid_o,
  output soc_pkg::data_t rdata_o,
  output logic           err_o,
  input  logic           uart_slverr_i,
  soc_bus_if.initiator   l2_o,
  soc_bus_if.initiator   uart_o,
  soc_bus_if.initiator   ctrl_o
);

  soc_pkg::soc_target_e tgt_d;
  soc_pkg::soc_target_e sel_q;
  logic                 req_q;
  logic                 busy_q;
  logic                 none_q;
  logic                 we_q;
  soc_pkg::addr_t       addr_q;
  soc_pkg::data_t       wdata_q;
  soc_pkg::strb_t       be_q;
  logic                 rvalid_mux;
  logic                 err_mux;
  soc_pkg::data_t       rdata_mux;

  // Region compare on the incoming address
  always_comb begin
    if (addr_i >= soc_pkg::DRAM_BASE &&
        addr_i <  soc_pkg::DRAM_BASE + soc_pkg::L2_LENGTH) begin
      tgt_d = soc_pkg::TGT_L2MEM;
    end else if (addr_i >= soc_pkg::UART_BASE &&
                 addr_i <  soc_pkg::UART_BASE + soc_pkg::UART_LENGTH) begin
      tgt_d = soc_pkg::TGT_UART;
    end else if (addr_i >= soc_pkg::CTRL_BASE &&
                 addr_i <  soc_pkg::CTRL_BASE + soc_pkg::CTRL_LENGTH) begin
      tgt_d = soc_pkg::TGT_CTRL;
    end else begin
      tgt_d = soc_pkg::TGT_NONE;
    end
  end

  // Selected target is held until its response returns
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q  <= 1'b0;
      busy_q <= 1'b0;
      none_q <= 1'b0;
      sel_q  <= soc_pkg::TGT_NONE;
    end else begin
      req_q  <= req_i;
      none_q <= req_q && (sel_q == soc_pkg::TGT_NONE);
      if (req_i) begin
        busy_q <= 1'b1;
        sel_q  <= tgt_d;
      end else if (resp_valid_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

  //////////////////////////////
  // Request fan-out
  //////////////////////////////

  assign l2_o.req   = req_q && (sel_q == soc_pkg::TGT_L2MEM);
  assign uart_o.req = req_q && (sel_q == soc_pkg::TGT_UART);
  assign ctrl_o.req = req_q && (sel_q == soc_pkg::TGT_CTRL);

  assign l2_o.we      = we_q;
  assign l2_o.addr    = addr_q;
  assign l2_o.wdata   = wdata_q;
  assign l2_o.be      = be_q;
  assign uart_o.we    = we_q;
  assign uart_o.addr  = addr_q;
  assign uart_o.wdata = wdata_q;
  assign uart_o.be    = be_q;
  assign ctrl_o.we    = we_q;
  assign ctrl_o.addr  = addr_q;
  assign ctrl_o.wdata = wdata_q;
  assign ctrl_o.be    = be_q;

  //////////////////////////////
  // Response mux
  //////////////////////////////

  always_comb begin
    rvalid_mux = 1'b0;
    rdata_mux  = '0;
    err_mux    = 1'b0;
    case (sel_q)
      soc_pkg::TGT_L2MEM: begin
        rvalid_mux = l2_o.rvalid;
        rdata_mux  = l2_o.rdata;
      end
      soc_pkg::TGT_UART: begin
        rvalid_mux = uart_o.rvalid;
        rdata_mux  = uart_o.rdata;
        err_mux    = uart_slverr_i;
      end
      soc_pkg::TGT_CTRL: begin
        rvalid_mux = ctrl_o.rvalid;
        rdata_mux  = ctrl_o.rdata;
      end
      default: begin
        rvalid_mux = none_q;
        err_mux    = 1'b1;
      end
    endcase
  end

  assign resp_valid_o = busy_q && rvalid_mux;
  assign rdata_o      = rdata_mux;
  assign err_o        = resp_valid_o && err_mux;

  // Initiator keeps one request in flight
  a_single_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i |-> !busy_q);

  // Only the selected target may answer
  a_rvalid_selected: assert property (@(posedge clk_i) disable iff (rst_i)
    (l2_o.rvalid || uart_o.rvalid || ctrl_o.rvalid) |->
      busy_q && $onehot({l2_o.rvalid, uart_o.rvalid, ctrl_o.rvalid}) &&
      ((l2_o.rvalid   && sel_q == soc_pkg::TGT_L2MEM) ||
       (uart_o.rvalid && sel_q == soc_pkg::TGT_UART)  ||
       (ctrl_o.rvalid && sel_q == soc_pkg::TGT_CTRL)));

endmodule

`default_nettype wire

// ==== source/soc_bus_if.sv ====
//////////////////////////////
// Request/response bus
// Decoder to target with one request in flight
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface soc_bus_if;

  logic           req;
  logic           we;
  soc_pkg::addr_t addr;
  soc_pkg::data_t wdata;
  soc_pkg::strb_t be;
  logic           rvalid;
  soc_pkg::data_t rdata;

  modport initiator (
    output req,
    output we,
    output addr,
    output wdata,
    output be,
    input  rvalid,
    input  rdata
  );

  modport target (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  be,
    output rvalid,
    output rdata
  );

endinterface

`default_nettype wire

// ==== source/soc_pkg.sv ====
//////////////////////////////
// SoC peripheral fabric package
// Memory map, bus widths, bus word types and decoder targets
//////////////////////////////

`default_nettype none

package soc_pkg;

  // Bus widths
  localparam int ADDR_WIDTH     = 32;
  localparam int DATA_WIDTH     = 64;
  localparam int STRB_WIDTH     = DATA_WIDTH / 8;
  localparam int APB_DATA_WIDTH = 32;

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [STRB_WIDTH-1:0]     strb_t;
  typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

  //////////////////////////////
  // Memory map
  //////////////////////////////

  localparam int    L2_NUM_WORDS = 256;
  localparam int    L2_IDX_WIDTH = $clog2(L2_NUM_WORDS);
  localparam int    BYTE_OFFSET  = $clog2(STRB_WIDTH);
  localparam addr_t DRAM_BASE    = 32'h8000_0000;
  localparam addr_t L2_LENGTH    = addr_t'(L2_NUM_WORDS * STRB_WIDTH);

  localparam addr_t UART_BASE    = 32'hC000_0000;
  localparam addr_t UART_LENGTH  = 32'h0000_1000;

  localparam addr_t CTRL_BASE    = 32'hD000_0000;
  localparam addr_t CTRL_LENGTH  = 32'h0000_1000;

  // Control register offsets
  localparam addr_t CTRL_EXIT_OFFSET   = 32'h0;
  localparam addr_t CTRL_CNT_EN_OFFSET = 32'h8;

  typedef enum logic [1:0] {
    TGT_L2MEM = 2'd0,
    TGT_UART  = 2'd1,
    TGT_CTRL  = 2'd2,
    TGT_NONE  = 2'd3
  } soc_target_e;

endpackage

`default_nettype wire

// ==== source/soc_top.sv ====
//////////////////////////////
// SoC peripheral fabric top
// Decoder, L2 memory, UART bridge and control registers
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module soc_top (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               req_i,
  input  logic               we_i,
  input  soc_pkg::addr_t     addr_i,
  input  soc_pkg::data_t     wdata_i,
  input  soc_pkg::strb_t     be_i,
  output logic               resp_valid_o,
  output soc_pkg::data_t     rdata_o,
  output logic               err_o,
  output soc_pkg::data_t     exit_o,
  output soc_pkg::data_t     hw_cnt_en_o,
  // UART APB
  output logic               uart_psel_o,
  output logic               uart_penable_o,
  output logic               uart_pwrite_o,
  output soc_pkg::addr_t     uart_paddr_o,
  output soc_pkg::apb_data_t uart_pwdata_o,
  input  soc_pkg::apb_data_t uart_prdata_i,
  input  logic               uart_pready_i,
  input  logic               uart_pslverr_i
);

  soc_bus_if l2_bus ();
  soc_bus_if uart_bus ();
  soc_bus_if ctrl_bus ();

  logic uart_slverr;

  soc_addr_decode soc_addr_decode_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .be_i          (be_i),
    .resp_valid_o  (resp_valid_o),
    .rdata_o       (rdata_o),
    .err_o         (err_o),
    .uart_slverr_i (uart_slverr),
    .l2_o          (l2_bus.initiator),
    .uart_o        (uart_bus.initiator),
    .ctrl_o        (ctrl_bus.initiator)
  );

  l2_mem l2_mem_inst (
    .clk_i (clk_i),
    .bus_i (l2_bus.target)
  );

  apb_uart_bridge apb_uart_bridge_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .bus_i     (uart_bus.target),
    .slverr_o  (uart_slverr),
    .psel_o    (uart_psel_o),
    .penable_o (uart_penable_o),
    .pwrite_o  (uart_pwrite_o),
    .paddr_o   (uart_paddr_o),
    .pwdata_o  (uart_pwdata_o),
    .prdata_i  (uart_prdata_i),
    .pready_i  (uart_pready_i),
    .pslverr_i (uart_pslverr_i)
  );

  ctrl_regs ctrl_regs_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_i       (ctrl_bus.target),
    .exit_o      (exit_o),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

endmodule

`default_nettype wire

// ==== tb.f ====
source/soc_pkg.sv
source/soc_bus_if.sv
source/soc_addr_decode.sv
source/l2_mem.sv
source/apb_uart_bridge.sv
source/ctrl_regs.sv
source/soc_top.sv
testbench/tb_soc_top.sv

// ==== testbench/tb_soc_top.sv ====
//////////////////////////////
// Testbench for the SoC peripheral fabric
// Table of bus requests with an APB UART responder model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;

  localparam int   NUM_ENTRIES  = 21;
  localparam int   TIMEOUT_CYC  = 40;
  localparam int   FAST_LAT     = 2;
  localparam int   SLOW_MIN_LAT = 4;
  localparam logic WR           = 1'b1;
  localparam logic RD           = 1'b0;
  localparam soc_pkg::data_t EXIT_VAL   = 64'h0000_0000_0000_002A;
  localparam soc_pkg::data_t CNT_EN_VAL = 64'h0000_0000_0000_0001;

  // data is wdata on a write and the expected rdata on a read
  typedef struct packed {
    logic           we;
    soc_pkg::addr_t addr;
    soc_pkg::data_t data;
    soc_pkg::strb_t be;
    logic           exp_err;
    logic           chk_rdata;
    logic           slow;
  } entry_t;

  logic               clk_i;
  logic               rst_i;
  logic               req_i;
  logic               we_i;
  soc_pkg::addr_t     addr_i;
  soc_pkg::data_t     wdata_i;
  soc_pkg::strb_t     be_i;
  logic               resp_valid_o;
  soc_pkg::data_t     rdata_o;
  logic               err_o;
  soc_pkg::data_t     exit_o;
  soc_pkg::data_t     hw_cnt_en_o;
  logic               uart_psel_o;
  logic               uart_penable_o;
  logic               uart_pwrite_o;
  soc_pkg::addr_t     uart_paddr_o;
  soc_pkg::apb_data_t uart_pwdata_o;
  soc_pkg::apb_data_t uart_prdata_i;
  logic               uart_pready_i;
  logic               uart_pslverr_i;

  entry_t             stim_table [0:NUM_ENTRIES-1];
  soc_pkg::apb_data_t uart_regs [0:3];
  integer             seed = 60;
  int                 pass_count = 0;
  int                 fail_count = 0;
  int                 apb_violations = 0;
  logic               timed_out;

  soc_top soc_top_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (req_i),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .resp_valid_o   (resp_valid_o),
    .rdata_o        (rdata_o),
    .err_o          (err_o),
    .exit_o         (exit_o),
    .hw_cnt_en_o    (hw_cnt_en_o),
    .uart_psel_o    (uart_psel_o),
    .uart_penable_o (uart_penable_o),
    .uart_pwrite_o  (uart_pwrite_o),
    .uart_paddr_o   (uart_paddr_o),
    .uart_pwdata_o  (uart_pwdata_o),
    .uart_prdata_i  (uart_prdata_i),
    .uart_pready_i  (uart_pready_i),
    .uart_pslverr_i (uart_pslverr_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic entry_t make_entry(input logic we, input soc_pkg::addr_t addr,
                                        input soc_pkg::data_t data, input soc_pkg::strb_t be,
                                        input int err, input int chk, input int slow);
    entry_t e;
    e.we        = we;
    e.addr      = addr;
    e.data      = data;
    e.be        = be;
    e.exp_err   = (err != 0);
    e.chk_rdata = (chk != 0);
    e.slow      = (slow != 0);
    return e;
  endfunction

  task automatic fill_table;
    // L2 memory with a partial-be merge at the end
    stim_table[0]  = make_entry(WR, 32'h8000_0000, 64'h1122_3344_5566_7788, 8'hFF, 0, 0, 0);
    stim_table[1]  = make_entry(WR, 32'h8000_0008, 64'hA5A5_5A5A_0F0F_F0F0, 8'hFF, 0, 0, 0);
    stim_table[2]  = make_entry(WR, 32'h8000_07F8, 64'hDEAD_BEEF_CAFE_F00D, 8'hFF, 0, 0, 0);
    stim_table[3]  = make_entry(RD, 32'h8000_0000, 64'h1122_3344_5566_7788, 8'hFF, 0, 1, 0);
    stim_table[4]  = make_entry(RD, 32'h8000_0008, 64'hA5A5_5A5A_0F0F_F0F0, 8'hFF, 0, 1, 0);
    stim_table[5]  = make_entry(RD, 32'h8000_07F8, 64'hDEAD_BEEF_CAFE_F00D, 8'hFF, 0, 1, 0);
    stim_table[6]  = make_entry(WR, 32'h8000_0000, 64'hFFEE_DDCC_BBAA_9988, 8'h0F, 0, 0, 0);
    stim_table[7]  = make_entry(RD, 32'h8000_0000, 64'h1122_3344_BBAA_9988, 8'hFF, 0, 1, 0);
    // Control registers
    stim_table[8]  = make_entry(WR, 32'hD000_0000, EXIT_VAL, 8'hFF, 0, 0, 0);
    stim_table[9]  = make_entry(WR, 32'hD000_0008, CNT_EN_VAL, 8'hFF, 0, 0, 0);
    stim_table[10] = make_entry(RD, 32'hD000_0000, EXIT_VAL, 8'hFF, 0, 1, 0);
    stim_table[11] = make_entry(RD, 32'hD000_0008, CNT_EN_VAL, 8'hFF, 0, 1, 0);
    stim_table[12] = make_entry(RD, 32'hD000_0010, 64'h0, 8'hFF, 0, 1, 0);
    // UART through APB with slave errors from offset 16 up
    stim_table[13] = make_entry(WR, 32'hC000_0004, 64'hFFFF_FFFF_1234_5678, 8'hFF, 0, 0, 1);
    stim_table[14] = make_entry(WR, 32'hC000_000C, 64'h0000_0000_CAFE_BABE, 8'hFF, 0, 0, 1);
    stim_table[15] = make_entry(RD, 32'hC000_0004, 64'h0000_0000_1234_5678, 8'hFF, 0, 1, 1);
    stim_table[16] = make_entry(RD, 32'hC000_000C, 64'h0000_0000_CAFE_BABE, 8'hFF, 0, 1, 1);
    stim_table[17] = make_entry(RD, 32'hC000_0010, 64'h0, 8'hFF, 1, 0, 1);
    stim_table[18] = make_entry(WR, 32'hC000_0020, 64'h0000_0000_0000_0055, 8'hFF, 1, 0, 1);
    // Unmapped
    stim_table[19] = make_entry(RD, 32'h0000_1000, 64'h0, 8'hFF, 1, 0, 0);
    stim_table[20] = make_entry(WR, 32'h0000_1000, 64'h0000_0000_0000_0077, 8'hFF, 1, 0, 0);
  endtask

  //////////////////////////////
  // APB UART model
  //////////////////////////////

  task automatic answer_apb;
    logic [1:0] idx;
    idx = uart_paddr_o[3:2];
    uart_pready_i = 1'b1;
    if (uart_paddr_o >= 32'd16) begin
      uart_pslverr_i = 1'b1;
      uart_prdata_i  = '0;
    end else begin
      uart_pslverr_i = 1'b0;
      if (uart_pwrite_o) begin
        uart_regs[idx] = uart_pwdata_o;
      end
      uart_prdata_i = uart_regs[idx];
    end
  endtask

  initial begin : apb_responder
    logic prev_psel;
    logic prev_penable;
    logic in_access;
    int   wait_left;
    prev_psel    = 1'b0;
    prev_penable = 1'b0;
    in_access    = 1'b0;
    wait_left    = 0;
    forever begin
      @(posedge clk_i);
      #2;
      if (uart_penable_o && !uart_psel_o) begin
        apb_violations++;
      end
      if (uart_psel_o && uart_penable_o) begin
        // First access cycle needs a setup cycle just before it
        if (!in_access) begin
          if (!(prev_psel && !prev_penable)) begin
            apb_violations++;
          end
          in_access = 1'b1;
          wait_left = $unsigned($random(seed)) % 4;
        end else if (wait_left > 0) begin
          wait_left--;
        end
        if (wait_left == 0 && !uart_pready_i) begin
          answer_apb();
        end
      end else begin
        in_access      = 1'b0;
        uart_pready_i  = 1'b0;
        uart_pslverr_i = 1'b0;
      end
      prev_psel    = uart_psel_o;
      prev_penable = uart_penable_o;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_reset_state;
    @(negedge clk_i);
    if (exit_o !== '0 || hw_cnt_en_o !== '0 || resp_valid_o !== 1'b0 ||
        uart_psel_o !== 1'b0 || err_o !== 1'b0) begin
      $display("ERR %0t ns: outputs not idle after reset", $time);
      $display("reset state: mismatch");
      fail_count++;
    end else begin
      $display("reset state: ok");
      pass_count++;
    end
  endtask

  task automatic run_entry(input int idx);
    entry_t e;
    int     lat;
    logic   seen;
    logic   ok;
    e    = stim_table[idx];
    ok   = 1'b1;
    seen = 1'b0;
    lat  = 0;
    @(posedge clk_i);
    #2;
    req_i   = 1'b1;
    we_i    = e.we;
    addr_i  = e.addr;
    wdata_i = e.we ? e.data : '0;
    be_i    = e.be;
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    while (!seen && lat < TIMEOUT_CYC) begin
      @(negedge clk_i);
      lat++;
      seen = resp_valid_o;
    end
    if (!seen) begin
      $display("Timeout: entry %0d got no response within %0d cycles", idx, TIMEOUT_CYC);
      timed_out = 1'b1;
      fail_count++;
    end else begin
      if (e.chk_rdata && rdata_o !== e.data) begin
        $display("ERR %0t ns: entry %0d rdata %h, expected %h", $time, idx, rdata_o, e.data);
        ok = 1'b0;
      end
      if (err_o !== e.exp_err) begin
        $display("ERR %0t ns: entry %0d err %b, expected %b", $time, idx, err_o, e.exp_err);
        ok = 1'b0;
      end
      if (e.slow && lat < SLOW_MIN_LAT) begin
        $display("ERR %0t ns: entry %0d latency %0d, expected at least %0d",
                 $time, idx, lat, SLOW_MIN_LAT);
        ok = 1'b0;
      end
      if (!e.slow && lat != FAST_LAT) begin
        $display("ERR %0t ns: entry %0d latency %0d, expected %0d", $time, idx, lat, FAST_LAT);
        ok = 1'b0;
      end
      if (ok) begin
        pass_count++;
      end else begin
        fail_count++;
      end
      $display("entry %0d: %s %h latency %0d %s", idx, e.we ? "write" : "read",
               e.addr, lat, ok ? "ok" : "mismatch");
    end
  endtask

  initial begin : main_seq
    rst_i          = 1'b1;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    wdata_i        = '0;
    be_i           = '0;
    uart_prdata_i  = '0;
    uart_pready_i  = 1'b0;
    uart_pslverr_i = 1'b0;
    timed_out      = 1'b0;
    for (int r = 0; r < 4; r++) begin
      uart_regs[r] = '0;
    end
    fill_table();
    repeat (8) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    check_reset_state();

    for (int i = 0; i < NUM_ENTRIES && !timed_out; i++) begin
      run_entry(i);
    end

    if (!timed_out) begin
      if (exit_o !== EXIT_VAL || hw_cnt_en_o !== CNT_EN_VAL) begin
        $display("ERR %0t ns: exit_o %h hw_cnt_en_o %h, expected %h %h",
                 $time, exit_o, hw_cnt_en_o, EXIT_VAL, CNT_EN_VAL);
        fail_count++;
      end else begin
        $display("control outputs: ok");
        pass_count++;
      end
      if (apb_violations != 0) begin
        $display("APB order: %0d transfers without a setup phase first", apb_violations);
        fail_count++;
      end else begin
        $display("APB order: ok");
        pass_count++;
      end
    end

    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (!timed_out && fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
